/* agu_stage.sv */
`default_nettype none

module agu_stage import lsu_pipe_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  access_op_t        op_i,
    input  access_sz_t        sz_i,
    input  logic              unsigned_i,
    input  logic [XLEN-1:0]   base_i,
    input  logic [15:0]       offset_i,
    input  logic [XLEN-1:0]   wdata_i,
    input  logic [REG_AW-1:0] rd_i,
    output logic              valid_o,
    output access_op_t        op_o,
    output access_sz_t        sz_o,
    output logic              unsigned_o,
    output logic [XLEN-1:0]   addr_o,
    output logic [XLEN-1:0]   wdata_o,
    output logic [REG_AW-1:0] rd_o,
    output logic              misalign_o
);

    logic [XLEN-1:0] addr;
    logic            mem_access;
    logic            align_err;
    logic            misalign;

    assign addr       = base_i + {{(XLEN-16){offset_i[15]}}, offset_i};
    assign mem_access = (op_i == OP_M2R) || (op_i == OP_R2M);

    always_comb begin
        case (sz_i)
            SZ_BYTE: align_err = 1'b0;
            SZ_HALF: align_err = addr[0];
            default: align_err = |addr[1:0];   // Word and the spare code
        endcase
    end

    // D2R never touches memory, so alignment does not apply to it
    assign misalign = align_err & mem_access;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o    <= 1'b0;
            misalign_o <= 1'b0;
        end else begin
            valid_o    <= valid_i;
            misalign_o <= valid_i & misalign;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o       <= misalign ? OP_D2R : op_i;   // Cancel the access
            sz_o       <= sz_i;
            unsigned_o <= unsigned_i;
            addr_o     <= addr;
            wdata_o    <= wdata_i;
            rd_o       <= rd_i;
        end
    end

    // Any access still headed for memory is aligned for its size
    a_mem_op_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_o && (op_o == OP_M2R || op_o == OP_R2M)
            |-> (sz_o != SZ_HALF || !addr_o[0])
             && (sz_o == SZ_BYTE || sz_o == SZ_HALF || addr_o[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

/* data_ram.sv */
`default_nettype none

module data_ram import lsu_pipe_pkg::*; (
    input  logic               clk_i,
    input  logic [DMEM_AW-1:0] addr_i,
    input  logic [XLEN-1:0]    wdata_i,
    input  logic [XLEN/8-1:0]  be_i,
    input  logic               we_i,
    output logic [XLEN-1:0]    rdata_o
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    assign rdata_o = mem[addr_i];   // Asynchronous read

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < XLEN/8; i++) begin
                if (be_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* lsu_pipe.f */
lsu_pipe_pkg.sv
agu_stage.sv
mem_stage.sv
data_ram.sv
lsu_pipe_top.sv
tb_lsu_pipe.sv

/* lsu_pipe_pkg.sv */
`default_nettype none

package lsu_pipe_pkg;

    localparam int XLEN       = 32;            // Data and address width
    localparam int REG_AW     = 5;             // Register number width
    localparam int DMEM_AW    = 8;             // Word index width, address bits 9..2
    localparam int DMEM_WORDS = 1 << DMEM_AW;

    // Code 2'b11 is not named and is handled as D2R
    typedef enum logic [1:0] {
        OP_D2R = 2'b00,                        // Pass operand to register
        OP_M2R = 2'b01,                        // Load
        OP_R2M = 2'b10                         // Store
    } access_op_t;

    // Code 2'b11 is not named and is handled as a word access
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } access_sz_t;

endpackage

`default_nettype wire

/* lsu_pipe_top.sv */
`default_nettype none

module lsu_pipe_top import lsu_pipe_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    input  access_op_t        in_op_i,
    input  access_sz_t        in_sz_i,
    input  logic              in_unsigned_i,
    input  logic [XLEN-1:0]   in_base_i,
    input  logic [15:0]       in_offset_i,
    input  logic [XLEN-1:0]   in_wdata_i,
    input  logic [REG_AW-1:0] in_rd_i,
    output logic              wb_valid_o,
    output logic              wb_we_o,
    output logic [REG_AW-1:0] wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o,
    output logic              misalign_o
);

    logic               ma_valid;
    access_op_t         ma_op;
    access_sz_t         ma_sz;
    logic               ma_unsigned;
    logic [XLEN-1:0]    ma_addr;
    logic [XLEN-1:0]    ma_wdata;
    logic [REG_AW-1:0]  ma_rd;
    logic               ma_misalign;

    logic [DMEM_AW-1:0] dm_addr;
    logic [XLEN-1:0]    dm_wdata;
    logic [XLEN/8-1:0]  dm_be;
    logic               dm_we;
    logic [XLEN-1:0]    dm_rdata;

    agu_stage u_agu (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (in_valid_i),
        .op_i       (in_op_i),
        .sz_i       (in_sz_i),
        .unsigned_i (in_unsigned_i),
        .base_i     (in_base_i),
        .offset_i   (in_offset_i),
        .wdata_i    (in_wdata_i),
        .rd_i       (in_rd_i),
        .valid_o    (ma_valid),
        .op_o       (ma_op),
        .sz_o       (ma_sz),
        .unsigned_o (ma_unsigned),
        .addr_o     (ma_addr),
        .wdata_o    (ma_wdata),
        .rd_o       (ma_rd),
        .misalign_o (ma_misalign)
    );

    mem_stage u_mem (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (ma_valid),
        .op_i       (ma_op),
        .sz_i       (ma_sz),
        .unsigned_i (ma_unsigned),
        .addr_i     (ma_addr),
        .wdata_i    (ma_wdata),
        .rd_i       (ma_rd),
        .misalign_i (ma_misalign),
        .dm_addr_o  (dm_addr),
        .dm_wdata_o (dm_wdata),
        .dm_be_o    (dm_be),
        .dm_we_o    (dm_we),
        .dm_rdata_i (dm_rdata),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .misalign_o (misalign_o)
    );

    data_ram u_dram (
        .clk_i   (clk_i),
        .addr_i  (dm_addr),
        .wdata_i (dm_wdata),
        .be_i    (dm_be),
        .we_i    (dm_we),
        .rdata_o (dm_rdata)
    );

endmodule

`default_nettype wire

/* mem_stage.sv */
`default_nettype none

module mem_stage import lsu_pipe_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               valid_i,
    input  access_op_t         op_i,
    input  access_sz_t         sz_i,
    input  logic               unsigned_i,
    input  logic [XLEN-1:0]    addr_i,
    input  logic [XLEN-1:0]    wdata_i,
    input  logic [REG_AW-1:0]  rd_i,
    input  logic               misalign_i,
    output logic [DMEM_AW-1:0] dm_addr_o,
    output logic [XLEN-1:0]    dm_wdata_o,
    output logic [XLEN/8-1:0]  dm_be_o,
    output logic               dm_we_o,
    input  logic [XLEN-1:0]    dm_rdata_i,
    output logic               wb_valid_o,
    output logic               wb_we_o,
    output logic [REG_AW-1:0]  wb_rd_o,
    output logic [XLEN-1:0]    wb_data_o,
    output logic               misalign_o
);

    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_data;
    logic [XLEN-1:0] wb_data;

    assign dm_addr_o = addr_i[DMEM_AW+1:2];   // Upper address bits alias

    always_comb begin
        case (sz_i)
            SZ_BYTE: dm_be_o = 4'b0001 << addr_i[1:0];
            SZ_HALF: dm_be_o = addr_i[1] ? 4'b1100 : 4'b0011;
            default: dm_be_o = 4'b1111;
        endcase
    end

    // Replicate so that every enabled lane sees the right bytes
    always_comb begin
        case (sz_i)
            SZ_BYTE: dm_wdata_o = {4{wdata_i[7:0]}};
            SZ_HALF: dm_wdata_o = {2{wdata_i[15:0]}};
            default: dm_wdata_o = wdata_i;
        endcase
    end

    // A misaligned access already arrives as D2R
    assign dm_we_o = valid_i & ~misalign_i & (op_i == OP_R2M);

    assign ld_byte = dm_rdata_i[8*addr_i[1:0] +: 8];
    assign ld_half = addr_i[1] ? dm_rdata_i[31:16] : dm_rdata_i[15:0];

    always_comb begin
        case (sz_i)
            SZ_BYTE: begin
                if (unsigned_i) begin
                    ld_data = {{(XLEN-8){1'b0}}, ld_byte};
                end else begin
                    ld_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
                end
            end
            SZ_HALF: begin
                if (unsigned_i) begin
                    ld_data = {{(XLEN-16){1'b0}}, ld_half};
                end else begin
                    ld_data = {{(XLEN-16){ld_half[15]}}, ld_half};
                end
            end
            default: ld_data = dm_rdata_i;
        endcase
    end

    assign wb_data = (op_i == OP_M2R) ? ld_data : wdata_i;   // Store and D2R pass operand

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            misalign_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
            wb_we_o    <= valid_i & ~misalign_i & (op_i != OP_R2M);
            misalign_o <= valid_i & misalign_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_rd_o   <= rd_i;
            wb_data_o <= wb_data;
        end
    end

    // A store that reaches memory never straddles its lanes
    a_store_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dm_we_o |-> (sz_i != SZ_HALF || !addr_i[0])
                 && (sz_i == SZ_BYTE || sz_i == SZ_HALF || addr_i[1:0] == 2'b00)
    );

    a_cancel_is_d2r: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) valid_i && misalign_i |-> op_i == OP_D2R
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the lsu_pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module tb_lsu_pipe -f lsu_pipe.f -o sim_lsu_pipe \
    && ./obj_dir/sim_lsu_pipe > "$LOG" 2>&1 \
    || { echo "Build or simulation did not complete"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "TEST FAILED" "$LOG" && exit 1
grep -q "TEST PASSED" "$LOG" || exit 1
exit 0

/* tb_lsu_pipe.sv */
`default_nettype none

module tb_lsu_pipe import lsu_pipe_pkg::*; ();

    localparam int RST_CYCLES  = 5;
    localparam int IDLE_CYCLES = 3;
    localparam int NUM_OPS     = 2000;
    localparam int DRAIN       = 4;
    // Random ops average 1.25 cycles each, so twice the op count is a safe bound
    localparam int TIMEOUT_CYCLES = RST_CYCLES + IDLE_CYCLES + DMEM_WORDS + 2 * NUM_OPS + 50;

    typedef struct packed {
        int                cyc;
        logic              we;
        logic              mis;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } exp_t;

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              in_valid_i;
    access_op_t        in_op_i;
    access_sz_t        in_sz_i;
    logic              in_unsigned_i;
    logic [XLEN-1:0]   in_base_i;
    logic [15:0]       in_offset_i;
    logic [XLEN-1:0]   in_wdata_i;
    logic [REG_AW-1:0] in_rd_i;
    logic              wb_valid_o;
    logic              wb_we_o;
    logic [REG_AW-1:0] wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;
    logic              misalign_o;

    logic [7:0] model_mem [1024];   // Byte image of address bits 9..0
    exp_t       exp_q [$];
    int         seed;
    int         cyc_cnt = 0;
    int         ops_sent = 0;
    int         checked = 0;
    int         val_errs = 0;
    int         proto_errs = 0;

    lsu_pipe_top u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_op_i       (in_op_i),
        .in_sz_i       (in_sz_i),
        .in_unsigned_i (in_unsigned_i),
        .in_base_i     (in_base_i),
        .in_offset_i   (in_offset_i),
        .in_wdata_i    (in_wdata_i),
        .in_rd_i       (in_rd_i),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .misalign_o    (misalign_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", cyc_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
            val_errs++;
        end
    endtask

    // Applies one operation to the byte model in issue order
    task automatic model_op(input access_op_t op, input access_sz_t sz, input logic uns,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [REG_AW-1:0] rd, output exp_t e);
        logic [9:0]  a;
        logic        bad;
        logic [7:0]  b;
        logic [15:0] h;
        a   = addr[9:0];
        bad = ((op == OP_M2R) || (op == OP_R2M)) &&
              ((sz == SZ_HALF && addr[0]) || (sz == SZ_WORD && addr[1:0] != 2'b00));
        e.cyc  = cyc_cnt;
        e.rd   = rd;
        e.mis  = bad;
        e.we   = !bad && (op != OP_R2M);
        e.data = wdata;                  // Store, D2R and cancelled ops
        b = model_mem[a];
        h = {model_mem[a + 10'd1], model_mem[a]};
        if (!bad && op == OP_R2M) begin
            model_mem[a] = wdata[7:0];
            if (sz != SZ_BYTE) begin
                model_mem[a + 10'd1] = wdata[15:8];
            end
            if (sz == SZ_WORD) begin
                model_mem[a + 10'd2] = wdata[23:16];
                model_mem[a + 10'd3] = wdata[31:24];
            end
        end else if (!bad && op == OP_M2R) begin
            if (sz == SZ_BYTE) begin
                e.data = uns ? {24'b0, b} : {{24{b[7]}}, b};
            end else if (sz == SZ_HALF) begin
                e.data = uns ? {16'b0, h} : {{16{h[15]}}, h};
            end else begin
                e.data = {model_mem[a + 10'd3], model_mem[a + 10'd2], h};
            end
        end
    endtask

    task automatic issue_op(input logic valid, input access_op_t op, input access_sz_t sz,
                            input logic uns, input logic [31:0] base, input logic [15:0] offset,
                            input logic [31:0] wdata, input logic [REG_AW-1:0] rd);
        exp_t e;
        in_valid_i    = valid;
        in_op_i       = op;
        in_sz_i       = sz;
        in_unsigned_i = uns;
        in_base_i     = base;
        in_offset_i   = offset;
        in_wdata_i    = wdata;
        in_rd_i       = rd;
        if (valid) begin
            model_op(op, sz, uns, base + {{16{offset[15]}}, offset}, wdata, rd, e);
            exp_q.push_back(e);
        end
    endtask

    task automatic issue_idle();
        issue_op(1'b0, OP_D2R, SZ_BYTE, 1'b0, $random(seed), 16'h0, $random(seed), '0);
    endtask

    task automatic issue_random();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] base;
        access_op_t  op;
        access_sz_t  sz;
        ra = $random(seed);
        rb = $random(seed);
        case (ra[1:0])
            2'd0:    op = OP_D2R;
            2'd2:    op = OP_R2M;
            default: op = OP_M2R;
        endcase
        case (ra[3:2])
            2'd0:    sz = SZ_BYTE;
            2'd1:    sz = SZ_HALF;
            default: sz = SZ_WORD;
        endcase
        base = 32'h100 + {25'b0, rb[6:0]};     // Small window, frequent collisions
        if (rb[9:8] == 2'b00) begin
            base = base | {rb[31:10], 10'b0};  // Upper bits alias
        end
        issue_op(ra[31:28] < 4'd13, op, sz, ra[4], base, {{9{ra[16]}}, ra[16:10]},
                 $random(seed), ra[9:5]);
        if (ra[31:28] < 4'd13) begin
            ops_sent++;
        end
    endtask

    // Outputs are settled at the falling edge
    task automatic tick();
        exp_t e;
        @(negedge clk_i);
        if (exp_q.size() != 0 && exp_q[0].cyc + 2 == cyc_cnt) begin
            e = exp_q.pop_front();
            assert (wb_valid_o === 1'b1) else begin
                $display("t=%0t: no writeback for the operation issued in cycle %0d",
                         $time, e.cyc);
                proto_errs++;
            end
            if (wb_valid_o === 1'b1) begin
                checked++;
                check_field("wb_we_o", {31'b0, e.we}, {31'b0, wb_we_o});
                check_field("misalign_o", {31'b0, e.mis}, {31'b0, misalign_o});
                check_field("wb_rd_o", {27'b0, e.rd}, {27'b0, wb_rd_o});
                check_field("wb_data_o", e.data, wb_data_o);
            end
        end else begin
            assert (wb_valid_o === 1'b0) else begin
                $display("t=%0t: wb_valid_o high with no operation due", $time);
                proto_errs++;
            end
        end
    endtask

    initial begin
        seed    = 32'h6fc709a7;
        rst_n_i = 1'b0;
        issue_op(1'b0, OP_D2R, SZ_BYTE, 1'b0, '0, '0, '0, '0);
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (IDLE_CYCLES) begin
            issue_idle();
            tick();
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            issue_op(1'b1, OP_R2M, SZ_WORD, 1'b0, i * 4, 16'h0,
                     (i * 4) * 32'h9e3779b1 ^ 32'h5a5a0f0f, '0);
            tick();
        end
        while (ops_sent < NUM_OPS) begin
            issue_random();
            tick();
        end
        repeat (DRAIN) begin
            issue_idle();
            tick();
        end
        $display("Summary: %0d writebacks checked, %0d value errors, %0d protocol errors",
                 checked, val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
